//--- Bender.yml
package:
  name: arena_vga

sources:
  - vga_timing_pkg.sv
  - arena_pkg.sv
  - scan_counter.sv
  - cell_locator.sv
  - tile_classifier.sv
  - pixel_painter.sv
  - arena_display.sv
  - target: test
    files:
      - arena_vga_tb.sv

//--- arena_display.sv
`default_nettype none

// arena game screen, counter -> locator -> classifier -> painter
// pixel at counter position p leaves three clocks later
module arena_display import vga_timing_pkg::*, arena_pkg::*; (
	input wire pixel_clk,
	input wire rst,
	input wire board_bits_t arena_i,	// 1 marks a brick block
	input wire bomb_board_t bombs_i,
	input wire player_pos_t player1_i,
	input wire player_pos_t player2_i,
	output rgb_t rgb_o,
	output logic hsync_o,
	output logic vsync_o
);

	scan_pos_t scan_pos;	// raw hc/vc
	locate_t locate;	// stage 1 out
	paint_t paint;	// stage 2 out
	sync_t sync;	// registered sync pair

	scan_counter scan_counter_i (
		.pixel_clk(pixel_clk),
		.rst(rst),
		.pos_o(scan_pos)
	);

	cell_locator cell_locator_i (
		.pixel_clk(pixel_clk),
		.rst(rst),
		.pos_i(scan_pos),
		.loc_o(locate)
	);

	tile_classifier tile_classifier_i (
		.pixel_clk(pixel_clk),
		.rst(rst),
		.loc_i(locate),
		.arena_i(arena_i),
		.bombs_i(bombs_i),
		.player1_i(player1_i),
		.player2_i(player2_i),
		.paint_o(paint)
	);

	pixel_painter pixel_painter_i (
		.pixel_clk(pixel_clk),
		.rst(rst),
		.paint_i(paint),
		.rgb_o(rgb_o),
		.sync_o(sync)
	);

	assign hsync_o = sync.hsync;	// split for the connector pins
	assign vsync_o = sync.vsync;

endmodule

`default_nettype wire

//--- arena_pkg.sv
`default_nettype none

package arena_pkg;

	import vga_timing_pkg::*;

	////////////////////////////////////////////////////////////
	// board geometry
	////////////////////////////////////////////////////////////

	localparam int GRID_ROWS = 10;
	localparam int GRID_COLS = 10;
	localparam int TILE_COUNT = GRID_ROWS * GRID_COLS;	// flat index is row*10+col
	localparam int TILE_W = 64;	// 640 / 10
	localparam int TILE_H = 48;	// 480 / 10

	typedef logic [3:0] tile_idx_t;	// row or column, 0..9
	typedef logic [5:0] tile_off_x_t;	// 0..63 inside a tile
	typedef logic [5:0] tile_off_y_t;	// 0..47 inside a tile

	typedef logic [1:0] bomb_state_t;	// 0 none, 1..3 fuse stages
	localparam bomb_state_t BOMB_NONE = 2'd0;

	typedef logic [TILE_COUNT-1:0] board_bits_t;	// arena blocks, one bit per tile
	typedef bomb_state_t [TILE_COUNT-1:0] bomb_board_t;

	typedef struct packed {
		tile_idx_t row;
		tile_idx_t col;
	} player_pos_t;

	typedef enum logic [2:0] {
		CELL_EMPTY,
		CELL_BLOCK,
		CELL_BOMB,
		CELL_PLAYER1,
		CELL_PLAYER2
	} cell_class_t;

	////////////////////////////////////////////////////////////
	// palette, 3:3:2 rgb
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [2:0] red;
		logic [2:0] green;
		logic [1:0] blue;
	} rgb_t;

	localparam rgb_t COL_BLANK = '{red: 3'd0, green: 3'd0, blue: 2'd0};	// outside window
	localparam rgb_t COL_BACKGROUND = '{red: 3'd7, green: 3'd7, blue: 2'd3};
	localparam rgb_t COL_BOMB1 = '{red: 3'd5, green: 3'd1, blue: 2'd3};	// fresh bomb
	localparam rgb_t COL_BOMB2 = '{red: 3'd4, green: 3'd0, blue: 2'd3};
	localparam rgb_t COL_BOMB3 = '{red: 3'd7, green: 3'd0, blue: 2'd0};	// about to blow
	localparam rgb_t COL_BRICK = '{red: 3'd6, green: 3'd2, blue: 2'd0};
	localparam rgb_t COL_MORTAR = '{red: 3'd0, green: 3'd0, blue: 2'd0};
	localparam rgb_t COL_PLAYER1 = '{red: 3'd0, green: 3'd7, blue: 2'd0};
	localparam rgb_t COL_PLAYER2 = '{red: 3'd0, green: 3'd0, blue: 2'd3};

	// brick joints, both lists have the same length
	localparam int MORTAR_N = 6;
	localparam tile_off_x_t MORTAR_COLS [MORTAR_N] = '{6'd0, 6'd13, 6'd26, 6'd39, 6'd52, 6'd63};
	localparam tile_off_y_t MORTAR_ROWS [MORTAR_N] = '{6'd0, 6'd9, 6'd19, 6'd29, 6'd39, 6'd47};

	// player body rectangle, bounds inclusive
	localparam tile_off_y_t BODY_ROW_FIRST = 6'd6;
	localparam tile_off_y_t BODY_ROW_LAST = 6'd41;
	localparam tile_off_x_t BODY_COL_FIRST = 6'd20;
	localparam tile_off_x_t BODY_COL_LAST = 6'd43;

	////////////////////////////////////////////////////////////
	// pipeline stage payloads
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic active;	// inside the 640x480 window
		sync_t sync;
		tile_idx_t row;
		tile_idx_t col;
		tile_off_x_t off_x;
		tile_off_y_t off_y;
	} locate_t;

	typedef struct packed {
		logic active;
		sync_t sync;
		cell_class_t cls;	// what the tile holds
		bomb_state_t bomb;	// picks the bomb colour
		tile_off_x_t off_x;
		tile_off_y_t off_y;
	} paint_t;

	localparam locate_t LOCATE_IDLE = '{active: 1'b0, sync: SYNC_IDLE,
		row: 4'd0, col: 4'd0, off_x: 6'd0, off_y: 6'd0};
	localparam paint_t PAINT_IDLE = '{active: 1'b0, sync: SYNC_IDLE,
		cls: CELL_EMPTY, bomb: BOMB_NONE, off_x: 6'd0, off_y: 6'd0};

endpackage

`default_nettype wire

//--- arena_vga.f
vga_timing_pkg.sv
arena_pkg.sv
scan_counter.sv
cell_locator.sv
tile_classifier.sv
pixel_painter.sv
arena_display.sv
arena_vga_tb.sv

//--- arena_vga_tb.sv
`default_nettype none

// self checking testbench, random board per frame and a pixel exact model
module arena_vga_tb import arena_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed {
		rgb_t rgb;
		logic hsync;
		logic vsync;
	} pixel_exp_t;

	localparam pixel_exp_t PIX_IDLE = '{rgb: 8'h00, hsync: 1'b1, vsync: 1'b1};
	localparam int RUN_LIMIT = 1_400_000;	// three frames take 1_250_400 clocks

	logic pixel_clk;
	logic rst;
	board_bits_t arena;
	bomb_board_t bombs;
	player_pos_t player1;
	player_pos_t player2;
	rgb_t rgb;
	logic hsync;
	logic vsync;

	logic [15:0] lfsr_state;
	int model_hc;	// counter position after the last rising edge
	int model_vc;
	int frames_done;
	int fills;	// boards drawn so far, picks the special case
	int cycles;
	pixel_exp_t exp_line [3];	// one slot per pipeline stage

	arena_display arena_display_i (
		.pixel_clk(pixel_clk),
		.rst(rst),
		.arena_i(arena),
		.bombs_i(bombs),
		.player1_i(player1),
		.player2_i(player2),
		.rgb_o(rgb),
		.hsync_o(hsync),
		.vsync_o(vsync)
	);

	////////////////////////////////////////////////////////////
	// random source and reference model
	////////////////////////////////////////////////////////////

	// galois form, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic draw_bits(input int n, output int val);
		val = 0;
		for (int i = 0; i < n; i++) begin
			val = val | (int'(lfsr_state[0]) << i);	// one step per bit
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// brick joints from the tile drawing
	function automatic logic mortar_at(input int ox, input int oy);
		case (ox)
			0, 13, 26, 39, 52, 63: return 1'b1;
			default: ;
		endcase
		case (oy)
			0, 9, 19, 29, 39, 47: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic pixel_exp_t expected_pixel(input int hc, input int vc,
		input board_bits_t brd, input bomb_board_t bmb, input player_pos_t p1,
		input player_pos_t p2);
		pixel_exp_t px;
		int row;
		int col;
		int ox;
		int oy;
		logic body;
		px.hsync = (hc >= 96);
		px.vsync = (vc >= 2);
		px.rgb = COL_BLANK;
		if (hc < 144 || hc >= 784 || vc < 31 || vc >= 511)
			return px;	// porches and pulses are black
		row = (vc - 31) / 48;
		col = (hc - 144) / 64;
		ox = (hc - 144) % 64;
		oy = (vc - 31) % 48;
		body = (oy >= 6) && (oy <= 41) && (ox >= 20) && (ox <= 43);
		case (bmb[row * 10 + col])
			2'd1: px.rgb = COL_BOMB1;
			2'd2: px.rgb = COL_BOMB2;
			2'd3: px.rgb = COL_BOMB3;
			default: begin
				if (row == p1.row && col == p1.col)
					px.rgb = body ? COL_PLAYER1 : COL_BACKGROUND;	// p1 beats p2
				else if (row == p2.row && col == p2.col)
					px.rgb = body ? COL_PLAYER2 : COL_BACKGROUND;
				else if (brd[row * 10 + col])
					px.rgb = mortar_at(ox, oy) ? COL_MORTAR : COL_BRICK;
				else
					px.rgb = COL_BACKGROUND;
			end
		endcase
		return px;
	endfunction

	task automatic check_value(input string name, input int got, input int want);
		if (got != want) begin
			$display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, want);
			$display("** FAIL **");
			$fatal(1, "output mismatch");
		end
	endtask

	// new board for the coming frame, frame 1 hides player1 under a bomb
	task automatic fill_board();
		int v;
		int tile;
		for (int t = 0; t < 100; t++) begin
			draw_bits(1, v);
			arena[t] = v[0];
			draw_bits(2, v);	// about one tile in four gets a bomb draw
			if (v == 0)
				draw_bits(2, v);
			else
				v = 0;
			bombs[t] = 2'(v);
		end
		draw_bits(4, v);
		player1.row = 4'(v % 10);
		draw_bits(4, v);
		player1.col = 4'(v % 10);
		draw_bits(4, v);
		player2.row = 4'(v % 10);
		draw_bits(4, v);
		player2.col = 4'(v % 10);
		tile = player1.row * 10 + player1.col;
		if (fills == 1) begin
			bombs[tile] = 2'd3;
		end else if (fills == 2) begin
			player2 = player1;	// shared tile, bomb cleared so the bodies show
			bombs[tile] = 2'd0;
		end
		fills++;
	endtask

	////////////////////////////////////////////////////////////
	// clock, stimulus and compare

	initial begin
		pixel_clk = 1'b0;
		forever #4 pixel_clk = ~pixel_clk;	// 125 MHz sim clock, 8 ns
	end

	// board changes on line 1, far from the first active line
	always @(negedge pixel_clk) begin
		if (!rst && model_hc == 0 && model_vc == 1)
			fill_board();
	end

	// step the model, then compare once the outputs have settled
	always @(posedge pixel_clk) begin
		if (!rst) begin
			exp_line[2] = exp_line[1];
			exp_line[1] = exp_line[0];
			exp_line[0] = expected_pixel(model_hc, model_vc, arena, bombs, player1, player2);
			if (model_hc == 799) begin
				model_hc = 0;
				if (model_vc == 520) begin
					model_vc = 0;
					frames_done++;
				end else begin
					model_vc++;
				end
			end else begin
				model_hc++;
			end
		end
		#2;
		check_value("rgb_o", int'(rgb), int'(exp_line[2].rgb));
		check_value("hsync_o", int'(hsync), int'(exp_line[2].hsync));
		check_value("vsync_o", int'(vsync), int'(exp_line[2].vsync));
	end

	initial begin
		rst = 1'b1;
		arena = '0;
		bombs = '0;
		player1 = '0;
		player2 = '0;
		lfsr_state = 16'd37635;
		model_hc = 0;
		model_vc = 0;
		frames_done = 0;
		fills = 0;
		cycles = 0;
		for (int i = 0; i < 3; i++)
			exp_line[i] = PIX_IDLE;	// pipeline holds idle pixels in reset
		repeat (16) @(negedge pixel_clk);
		rst = 1'b0;
		while (frames_done < 3 && cycles < RUN_LIMIT) begin
			@(negedge pixel_clk);
			cycles++;
		end
		if (frames_done < 3) begin
			$display("run timed out after %0d cycles, %0d frames done", cycles, frames_done);
			$display("** FAIL **");
			$fatal(1, "timeout");
		end else begin
			$display("** PASS **");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- cell_locator.sv
`default_nettype none

// first stage, turns the raster position into a tile and an offset in it
module cell_locator import vga_timing_pkg::*, arena_pkg::*; (
	input wire pixel_clk,
	input wire rst,
	input wire scan_pos_t pos_i,
	output locate_t loc_o
);

	logic h_act;	// hc inside 144..783
	logic v_act;	// vc inside 31..510
	logic line_start;	// first active column of any line
	locate_t loc_n;

	assign h_act = (pos_i.hc >= H_ACTIVE_START) && (pos_i.hc < H_ACTIVE_END);
	assign v_act = (pos_i.vc >= V_ACTIVE_START) && (pos_i.vc < V_ACTIVE_END);
	assign line_start = (pos_i.hc == H_ACTIVE_START);

	////////////////////////////////////////////////////////////
	// running tile counters, no divide by 64 or 48
	////////////////////////////////////////////////////////////

	always_comb begin
		loc_n = loc_o;	// the counters live in the output register

		loc_n.active = h_act && v_act;
		loc_n.sync.hsync = (pos_i.hc >= H_PULSE);	// low for hc 0..95
		loc_n.sync.vsync = (pos_i.vc >= V_PULSE);	// low for lines 0 and 1

		// horizontal, restart at the left edge of the window
		if (line_start) begin
			loc_n.col = '0;
			loc_n.off_x = '0;
		end else begin
			loc_n.off_x = loc_o.off_x + 6'd1;	// 6 bits wrap at 64 by themselves
			if (loc_o.off_x == TILE_W - 1)
				loc_n.col = loc_o.col + 4'd1;	// next tile to the right
		end

		// vertical, one step per active line taken at its first pixel
		if (line_start) begin
			if (pos_i.vc == V_ACTIVE_START) begin
				loc_n.row = '0;	// top of the board
				loc_n.off_y = '0;
			end else if (v_act) begin
				if (loc_o.off_y == TILE_H - 1) begin
					loc_n.off_y = '0;
					loc_n.row = loc_o.row + 4'd1;
				end else begin
					loc_n.off_y = loc_o.off_y + 6'd1;
				end
			end
			// blanking lines keep the last row
		end
	end

	always_ff @(posedge pixel_clk or posedge rst) begin
		if (rst)
			loc_o <= LOCATE_IDLE;	// sync high, inactive
		else
			loc_o <= loc_n;
	end

	// the running counters never leave the board while drawing
	a_tile_on_board: assert property (
		@(posedge pixel_clk) disable iff (rst)
		loc_o.active |-> (loc_o.row < GRID_ROWS) && (loc_o.col < GRID_COLS)
	);

endmodule

`default_nettype wire

//--- pixel_painter.sv
`default_nettype none

// last stage, turns class and offset into a colour and drives the pins
module pixel_painter import vga_timing_pkg::*, arena_pkg::*; (
	input wire pixel_clk,
	input wire rst,
	input wire paint_t paint_i,
	output rgb_t rgb_o,
	output sync_t sync_o
);

	logic on_mortar;	// offset sits on a joint of the brick pattern
	logic in_body;	// offset inside the player rectangle
	rgb_t bomb_rgb;
	rgb_t rgb_n;

	////////////////////////////////////////////////////////////
	// tile art
	////////////////////////////////////////////////////////////

	// mortar is any listed column or any listed row
	always_comb begin
		on_mortar = 1'b0;
		for (int i = 0; i < MORTAR_N; i++) begin
			if ((paint_i.off_x == MORTAR_COLS[i]) || (paint_i.off_y == MORTAR_ROWS[i]))
				on_mortar = 1'b1;
		end
	end

	assign in_body = (paint_i.off_y >= BODY_ROW_FIRST) && (paint_i.off_y <= BODY_ROW_LAST) &&
		(paint_i.off_x >= BODY_COL_FIRST) && (paint_i.off_x <= BODY_COL_LAST);

	// fuse stage to colour, whole tile is flat
	always_comb begin
		case (paint_i.bomb)
			2'd1: bomb_rgb = COL_BOMB1;
			2'd2: bomb_rgb = COL_BOMB2;
			2'd3: bomb_rgb = COL_BOMB3;
			default: bomb_rgb = COL_BACKGROUND;	// no bomb, never picked for CELL_BOMB
		endcase
	end

	always_comb begin
		rgb_n = COL_BLANK;	// porches and sync stay black
		if (paint_i.active) begin
			case (paint_i.cls)
				CELL_BOMB: rgb_n = bomb_rgb;
				CELL_BLOCK: rgb_n = on_mortar ? COL_MORTAR : COL_BRICK;
				CELL_PLAYER1: rgb_n = in_body ? COL_PLAYER1 : COL_BACKGROUND;
				CELL_PLAYER2: rgb_n = in_body ? COL_PLAYER2 : COL_BACKGROUND;
				default: rgb_n = COL_BACKGROUND;	// empty floor
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// output register, colour and sync leave together

	always_ff @(posedge pixel_clk or posedge rst) begin
		if (rst) begin
			rgb_o <= COL_BLANK;
			sync_o <= SYNC_IDLE;
		end else begin
			rgb_o <= rgb_n;
			sync_o <= paint_i.sync;
		end
	end

	// nothing lit outside the window one cycle later
	a_blank_when_inactive: assert property (
		@(posedge pixel_clk) disable iff (rst)
		!paint_i.active |=> (rgb_o == COL_BLANK)
	);

endmodule

`default_nettype wire

//--- scan_counter.sv
`default_nettype none

// free running raster position, one step per pixel clock
module scan_counter import vga_timing_pkg::*; (
	input wire pixel_clk,
	input wire rst,	// async, active high
	output scan_pos_t pos_o
);

	logic line_end;	// last pixel of the line
	logic frame_end;	// last line of the frame

	assign line_end = (pos_o.hc == H_TOTAL - 10'd1);
	assign frame_end = (pos_o.vc == V_TOTAL - 10'd1);

	////////////////////////////////////////////////////////////
	// hc runs 0..799, vc advances on the hc wrap

	always_ff @(posedge pixel_clk or posedge rst) begin
		if (rst) begin
			pos_o.hc <= '0;
			pos_o.vc <= '0;
		end else begin
			if (line_end) begin
				pos_o.hc <= '0;
				// vc wraps after line 520
				if (frame_end)
					pos_o.vc <= '0;
				else
					pos_o.vc <= pos_o.vc + 10'd1;
			end else begin
				pos_o.hc <= pos_o.hc + 10'd1;	// vc holds inside a line
			end
		end
	end

	// both counts stay inside the frame
	a_scan_in_range: assert property (
		@(posedge pixel_clk) disable iff (rst)
		(pos_o.hc < H_TOTAL) && (pos_o.vc < V_TOTAL)
	);

endmodule

`default_nettype wire

//--- tile_classifier.sv
`default_nettype none

// second stage, looks the tile up on the board and picks what to draw
module tile_classifier import arena_pkg::*; (
	input wire pixel_clk,
	input wire rst,
	input wire locate_t loc_i,
	input wire board_bits_t arena_i,
	input wire bomb_board_t bombs_i,
	input wire player_pos_t player1_i,
	input wire player_pos_t player2_i,
	output paint_t paint_o
);

	logic [6:0] tile_idx;	// flat board index, row*10+col
	logic tile_in;	// pixel drawn and index on the board
	bomb_state_t tile_bomb;
	logic tile_block;
	logic on_p1;
	logic on_p2;
	cell_class_t cls;
	paint_t paint_n;

	assign tile_idx = 7'(loc_i.row * GRID_COLS + loc_i.col);
	// col runs past 9 in the blanking, keep those lookups off the board
	assign tile_in = loc_i.active && (tile_idx < TILE_COUNT);

	assign tile_bomb = tile_in ? bombs_i[tile_idx] : BOMB_NONE;
	assign tile_block = tile_in && arena_i[tile_idx];

	assign on_p1 = (loc_i.row == player1_i.row) && (loc_i.col == player1_i.col);
	assign on_p2 = (loc_i.row == player2_i.row) && (loc_i.col == player2_i.col);

	////////////////////////////////////////////////////////////
	// class priority
	////////////////////////////////////////////////////////////

	always_comb begin
		if (tile_bomb != BOMB_NONE)
			cls = CELL_BOMB;	// a bomb hides whoever stands on it
		else if (on_p1)
			cls = CELL_PLAYER1;	// player1 wins a shared tile
		else if (on_p2)
			cls = CELL_PLAYER2;
		else if (tile_block)
			cls = CELL_BLOCK;
		else
			cls = CELL_EMPTY;
	end

	always_comb begin
		paint_n.active = loc_i.active;
		paint_n.sync = loc_i.sync;	// sync just rides along
		paint_n.cls = cls;
		paint_n.bomb = tile_bomb;
		paint_n.off_x = loc_i.off_x;	// painter needs the in-tile position
		paint_n.off_y = loc_i.off_y;
	end

	always_ff @(posedge pixel_clk or posedge rst) begin
		if (rst)
			paint_o <= PAINT_IDLE;
		else
			paint_o <= paint_n;
	end

endmodule

`default_nettype wire

//--- vga_timing_pkg.sv
`default_nettype none

package vga_timing_pkg;

	////////////////////////////////////////////////////////////
	// scan geometry for 640x480 at a 25 MHz pixel clock
	////////////////////////////////////////////////////////////

	typedef logic [9:0] scan_cnt_t;	// holds up to 1023, enough for 800 and 521

	localparam scan_cnt_t H_TOTAL = 10'd800;	// pixels per line incl. blanking
	localparam scan_cnt_t V_TOTAL = 10'd521;	// lines per frame incl. blanking

	// sync pulses start at count 0
	localparam scan_cnt_t H_PULSE = 10'd96;	// hsync low while hc < 96
	localparam scan_cnt_t V_PULSE = 10'd2;	// vsync low for the first two lines

	// window start is sync pulse plus back porch
	localparam scan_cnt_t H_ACTIVE_START = 10'd144;
	localparam scan_cnt_t V_ACTIVE_START = 10'd31;
	localparam scan_cnt_t H_ACTIVE = 10'd640;
	localparam scan_cnt_t V_ACTIVE = 10'd480;

	// first count past the window, range is half open
	localparam scan_cnt_t H_ACTIVE_END = H_ACTIVE_START + H_ACTIVE;	// 784
	localparam scan_cnt_t V_ACTIVE_END = V_ACTIVE_START + V_ACTIVE;	// 511

	typedef struct packed {
		scan_cnt_t hc;	// pixel within the line
		scan_cnt_t vc;	// line within the frame
	} scan_pos_t;

	typedef struct packed {
		logic hsync;	// active low
		logic vsync;	// active low
	} sync_t;

	// both pulses released, used as the reset level of every stage
	localparam sync_t SYNC_IDLE = '{hsync: 1'b1, vsync: 1'b1};

endpackage

`default_nettype wire
